/* Makefile */
# Verilator build and run of the FFT butterfly testbench
# all of these may be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_fft_butterfly
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv) $(wildcard test/*.sv) src/twiddle_q14.hex

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
src/butterfly_pkg.sv
src/twiddle_pkg.sv
src/twiddle_lut.sv
src/butterfly_pipe.sv
src/result_fifo.sv
src/fft_butterfly.sv
test/clk_gen.sv
test/tb_fft_butterfly.sv

/* src/butterfly_pipe.sv */
/*
 * three-stage butterfly datapath, X = (A+B)/2 and Y = (A-B)*W/2
 * one item per stage, no stall, push marks a finished result
 */
module butterfly_pipe import butterfly_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic signed [SAMPLE_W-1:0]  a_re,
    input  logic signed [SAMPLE_W-1:0]  a_im,
    input  logic signed [SAMPLE_W-1:0]  b_re,
    input  logic signed [SAMPLE_W-1:0]  b_im,
    input  logic signed [TWIDDLE_W-1:0] w_re,
    input  logic signed [TWIDDLE_W-1:0] w_im,
    output logic                        push,
    output logic signed [SAMPLE_W-1:0]  x_re,
    output logic signed [SAMPLE_W-1:0]  x_im,
    output logic signed [SAMPLE_W-1:0]  y_re,
    output logic signed [SAMPLE_W-1:0]  y_im
);

    localparam int ACC_W = PROD_W + 1;

    logic                     v1;
    logic signed [SUM_W-1:0]  sum_re1, sum_im1, dif_re1, dif_im1;

    logic                     v2;
    logic signed [SUM_W-1:0]  sum_re2, sum_im2;
    logic signed [PROD_W-1:0] p_rr, p_ii, p_ri, p_ir;

    logic signed [ACC_W-1:0]  y_re_full;
    logic signed [ACC_W-1:0]  y_im_full;

    // valid chain, the only control state here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v1   <= 1'b0;
            v2   <= 1'b0;
            push <= 1'b0;
        end else begin
            v1   <= in_valid;
            v2   <= v1;
            push <= v2;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 1, sums and differences, lines up with the twiddle read
    always_ff @(posedge clk) begin
        if (in_valid) begin
            sum_re1 <= SUM_W'(a_re) + SUM_W'(b_re);
            sum_im1 <= SUM_W'(a_im) + SUM_W'(b_im);
            dif_re1 <= SUM_W'(a_re) - SUM_W'(b_re);
            dif_im1 <= SUM_W'(a_im) - SUM_W'(b_im);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2, four partial products
    always_ff @(posedge clk) begin
        if (v1) begin
            sum_re2 <= sum_re1;
            sum_im2 <= sum_im1;
            p_rr    <= PROD_W'(dif_re1) * PROD_W'(w_re);
            p_ii    <= PROD_W'(dif_im1) * PROD_W'(w_im);
            p_ri    <= PROD_W'(dif_re1) * PROD_W'(w_im);
            p_ir    <= PROD_W'(dif_im1) * PROD_W'(w_re);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 3, combine, scale and truncate
    assign y_re_full = ACC_W'(p_rr) - ACC_W'(p_ii);
    assign y_im_full = ACC_W'(p_ri) + ACC_W'(p_ir);

    always_ff @(posedge clk) begin
        if (v2) begin
            x_re <= SAMPLE_W'(sum_re2 >>> 1);
            x_im <= SAMPLE_W'(sum_im2 >>> 1);
            y_re <= SAMPLE_W'(y_re_full >>> Y_SHIFT);
            y_im <= SAMPLE_W'(y_im_full >>> Y_SHIFT);
        end
    end

    a_push_latency: assert property (
        @(posedge clk) disable iff (rst)
        push == $past(in_valid, 3)
    ) else $error("push does not trail in_valid by three cycles");

endmodule

/* src/butterfly_pkg.sv */
/*
 * datapath widths and fixed-point scaling of the radix-2 butterfly
 * imported by the pipeline, the output queue and the top level
 */
package butterfly_pkg;

    // real or imaginary part of a sample at the ports
    localparam int SAMPLE_W = 16;

    // twiddle parts are signed Q2.14, so +1.0 fits exactly
    localparam int TWIDDLE_W = 16;
    localparam int TWIDDLE_FRAC = 14;

    // A+B and A-B keep one growth bit
    localparam int SUM_W = SAMPLE_W + 1;

    // full-width difference times twiddle part
    localparam int PROD_W = SUM_W + TWIDDLE_W;

    // drop the Q14 fraction and halve Y
    localparam int Y_SHIFT = TWIDDLE_FRAC + 1;

endpackage

/* src/fft_butterfly.sv */
/*
 * radix-2 FFT butterfly with built-in twiddle generator
 * credit flow control toward upstream and from downstream
 */
module fft_butterfly import butterfly_pkg::*, twiddle_pkg::*; #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic signed [SAMPLE_W-1:0] a_re,
    input  logic signed [SAMPLE_W-1:0] a_im,
    input  logic signed [SAMPLE_W-1:0] b_re,
    input  logic signed [SAMPLE_W-1:0] b_im,
    input  logic [PHASE_W-1:0]         phase,
    output logic                       in_credit,
    output logic                       out_valid,
    output logic signed [SAMPLE_W-1:0] x_re,
    output logic signed [SAMPLE_W-1:0] x_im,
    output logic signed [SAMPLE_W-1:0] y_re,
    output logic signed [SAMPLE_W-1:0] y_im,
    input  logic                       out_credit
);

    logic signed [TWIDDLE_W-1:0] w_re;
    logic signed [TWIDDLE_W-1:0] w_im;
    logic                        push;
    logic signed [SAMPLE_W-1:0]  pipe_x_re;
    logic signed [SAMPLE_W-1:0]  pipe_x_im;
    logic signed [SAMPLE_W-1:0]  pipe_y_re;
    logic signed [SAMPLE_W-1:0]  pipe_y_im;

    twiddle_lut u_twiddle_lut (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .phase    (phase),
        .w_re     (w_re),
        .w_im     (w_im)
    );

    // twiddle arrives together with stage 1 of the pipe
    butterfly_pipe u_butterfly_pipe (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .a_re     (a_re),
        .a_im     (a_im),
        .b_re     (b_re),
        .b_im     (b_im),
        .w_re     (w_re),
        .w_im     (w_im),
        .push     (push),
        .x_re     (pipe_x_re),
        .x_im     (pipe_x_im),
        .y_re     (pipe_y_re),
        .y_im     (pipe_y_im)
    );

    result_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_result_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .x_re       (pipe_x_re),
        .x_im       (pipe_x_im),
        .y_re       (pipe_y_re),
        .y_im       (pipe_y_im),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .in_credit  (in_credit),
        .out_x_re   (x_re),
        .out_x_im   (x_im),
        .out_y_re   (y_re),
        .out_y_im   (y_im)
    );

endmodule

/* src/result_fifo.sv */
/*
 * result queue between the butterfly pipeline and downstream
 * pops only against downstream credits and hands one credit back upstream per pop
 */
module result_fifo import butterfly_pkg::*; #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  logic signed [SAMPLE_W-1:0] x_re,
    input  logic signed [SAMPLE_W-1:0] x_im,
    input  logic signed [SAMPLE_W-1:0] y_re,
    input  logic signed [SAMPLE_W-1:0] y_im,
    input  logic                       out_credit,
    output logic                       out_valid,
    output logic                       in_credit,
    output logic signed [SAMPLE_W-1:0] out_x_re,
    output logic signed [SAMPLE_W-1:0] out_x_im,
    output logic signed [SAMPLE_W-1:0] out_y_re,
    output logic signed [SAMPLE_W-1:0] out_y_im
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    logic [4*SAMPLE_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic [CRD_W-1:0]      credits;
    logic                  pop;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop       = (count != '0) && (credits != '0);
    assign out_valid = pop;
    assign in_credit = pop;

    assign {out_x_re, out_x_im, out_y_re, out_y_im} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {x_re, x_im, y_re, y_im};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRD_W'(OUT_CREDITS);
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // a returned credit and a spent one cancel
            case ({out_credit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: ;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        push |-> count < CNT_W'(FIFO_DEPTH)
    ) else $error("push into a full result queue");

    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credits <= CRD_W'(OUT_CREDITS)
    ) else $error("downstream returned more credits than it was given");

endmodule

/* src/twiddle_lut.sv */
/*
 * twiddle generator, W = cos - j sin of the input phase
 * octant folding over a 0..45 degree table, result registered one cycle later
 */
module twiddle_lut import butterfly_pkg::*, twiddle_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic [PHASE_W-1:0]          phase,
    output logic signed [TWIDDLE_W-1:0] w_re,
    output logic signed [TWIDDLE_W-1:0] w_im
);

    localparam int INDEX_W = $clog2(TABLE_SIZE);

    logic [2*TWIDDLE_W-1:0] rom [TABLE_SIZE];

    twiddle_phase_u              ph;
    logic [INDEX_W-1:0]          idx;
    logic signed [TWIDDLE_W-1:0] c;
    logic signed [TWIDDLE_W-1:0] s;
    logic                        swap;
    logic                        neg_cos;
    logic                        neg_sin;
    logic signed [TWIDDLE_W-1:0] mag_cos;
    logic signed [TWIDDLE_W-1:0] mag_sin;

    initial begin
        $readmemh(TABLE_FILE, rom);
    end

    assign ph.raw = phase;

    // odd octants run the table backwards
    assign idx = ph.split.octant[0] ?
                 INDEX_W'(TABLE_SIZE - 1) - INDEX_W'(ph.split.offset) :
                 INDEX_W'(ph.split.offset);

    assign {c, s} = rom[idx];

    // octants 1,2,5,6 exchange cos and sin
    assign swap    = ph.split.octant[0] ^ ph.split.octant[1];
    // cos negative from 90 to 270 degrees, sin negative past 180
    assign neg_cos = ph.split.octant[2] ^ ph.split.octant[1];
    assign neg_sin = ph.split.octant[2];

    assign mag_cos = swap ? s : c;
    assign mag_sin = swap ? c : s;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            w_re <= '0;
            w_im <= '0;
        end else if (in_valid) begin
            w_re <= neg_cos ? -mag_cos : mag_cos;
            // imaginary part carries -sin
            w_im <= neg_sin ? mag_sin : -mag_sin;
        end
    end

    a_index_range: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |-> idx <= INDEX_W'(TABLE_SIZE - 1)
    ) else $error("twiddle table index %0d out of range", idx);

endmodule

/* src/twiddle_pkg.sv */
/*
 * phase word layout and twiddle table geometry
 * the octant/offset view of the phase drives the folded table lookup
 */
package twiddle_pkg;

    // phase counts 1/256 of a full turn
    localparam int PHASE_W = 8;

    // top bits pick one of eight 45 degree octants
    localparam int OCTANT_W = 3;
    localparam int OFFSET_W = PHASE_W - OCTANT_W;

    // 0 to 45 degrees inclusive, both ends stored
    localparam int TABLE_SIZE = 2 ** OFFSET_W + 1;

    // one word per line, cos in the upper half and sin in the lower
    localparam string TABLE_FILE = "src/twiddle_q14.hex";

    typedef struct packed {
        logic [OCTANT_W-1:0] octant;
        logic [OFFSET_W-1:0] offset;
    } twiddle_split_t;

    // same bits seen as a plain angle or as octant plus offset
    typedef union packed {
        logic [PHASE_W-1:0] raw;
        twiddle_split_t     split;
    } twiddle_phase_u;

endpackage

/* src/twiddle_q14.hex */
// entry k = cos (upper 16 bits) then sin (lower 16 bits) of 2*pi*k/256, Q2.14
40000000
3FFB0192
3FEC0324
3FD404B5
3FB10646
3F8507D6
3F4F0964
3F0F0AF1
3EC50C7C
3E720E06
3E150F8D
3DAF1112
3D3F1294
3CC51413
3C421590
3BB61709
3B21187E
3A8219EF
39DB1B5D
392B1CC6
38711E2B
37B01F8C
36E520E7
3612223D
3537238E
345324DA
33682620
32742760
3179289A
307629CE
2F6C2AFB
2E5A2C21
2D412D41

/* test/clk_gen.sv */
/*
 * testbench clock and reset source
 * reset is held for a set number of rising edges, then released on an edge
 */
module clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* test/tb_fft_butterfly.sv */
/*
 * directed testbench for the FFT butterfly as upstream and downstream credit partner
 * results are checked in order against a model built from the twiddle table file
 */
module tb_fft_butterfly import butterfly_pkg::*, twiddle_pkg::*; ();

    localparam int FIFO_DEPTH      = 4;
    localparam int OUT_CREDITS     = 2;
    localparam int CLK_PERIOD      = 8;
    localparam int PHASE0_ITEMS    = 16;
    localparam int SWEEP_ITEMS     = 2 ** PHASE_W;
    localparam int BP_ITEMS        = FIFO_DEPTH + OUT_CREDITS + 2;
    localparam int BURST_ITEMS     = 40;
    localparam int TOTAL_ITEMS     = PHASE0_ITEMS + SWEEP_ITEMS + BP_ITEMS + BURST_ITEMS;
    localparam int QUIET_CYCLES    = 16;
    localparam int DRAIN_LIMIT     = 200;
    localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 12 + 1000;

    logic                       clk;
    logic                       rst;
    logic                       in_valid;
    logic signed [SAMPLE_W-1:0] a_re;
    logic signed [SAMPLE_W-1:0] a_im;
    logic signed [SAMPLE_W-1:0] b_re;
    logic signed [SAMPLE_W-1:0] b_im;
    logic [PHASE_W-1:0]         phase;
    logic                       in_credit;
    logic                       out_valid;
    logic signed [SAMPLE_W-1:0] x_re;
    logic signed [SAMPLE_W-1:0] x_im;
    logic signed [SAMPLE_W-1:0] y_re;
    logic signed [SAMPLE_W-1:0] y_im;
    logic                       out_credit = 1'b0;
    logic                       hold_credits = 1'b0;

    logic [15:0]                lfsr;
    logic [2*TWIDDLE_W-1:0]     twiddle_table [TABLE_SIZE];
    logic signed [SAMPLE_W-1:0] exp_x_re [$];
    logic signed [SAMPLE_W-1:0] exp_x_im [$];
    logic signed [SAMPLE_W-1:0] exp_y_re [$];
    logic signed [SAMPLE_W-1:0] exp_y_im [$];
    int sent_count = 0;
    int out_count = 0;
    int in_credit_count = 0;
    int returned_count = 0;
    int pass_count = 0;
    int fail_count = 0;

    clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clk_gen (.clk(clk), .rst(rst));

    fft_butterfly #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_fft_butterfly (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .a_re       (a_re),
        .a_im       (a_im),
        .b_re       (b_re),
        .b_im       (b_im),
        .phase      (phase),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .x_re       (x_re),
        .x_im       (x_im),
        .y_re       (y_re),
        .y_im       (y_im),
        .out_credit (out_credit)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[15]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic int upstream_credits();
        return FIFO_DEPTH - sent_count + in_credit_count;
    endfunction

    // model of W = cos - j sin with the octant rule applied to the table
    function automatic void expect_result(
        input logic signed [SAMPLE_W-1:0] ar,
        input logic signed [SAMPLE_W-1:0] ai,
        input logic signed [SAMPLE_W-1:0] br,
        input logic signed [SAMPLE_W-1:0] bi,
        input logic [PHASE_W-1:0]         ph
    );
        logic [OCTANT_W-1:0] oct;
        int                  idx;
        longint              c;
        longint              s;
        longint              cos_v;
        longint              sin_v;
        longint              dre;
        longint              dim;
        oct = ph[PHASE_W-1 -: OCTANT_W];
        idx = int'(ph[OFFSET_W-1:0]);
        if (oct[0])
            idx = (TABLE_SIZE - 1) - idx;
        c = longint'($signed(twiddle_table[idx][2*TWIDDLE_W-1:TWIDDLE_W]));
        s = longint'($signed(twiddle_table[idx][TWIDDLE_W-1:0]));
        case (oct)
            3'd0, 3'd7: cos_v = c;
            3'd1, 3'd6: cos_v = s;
            3'd2, 3'd5: cos_v = -s;
            default:    cos_v = -c;
        endcase
        case (oct)
            3'd0, 3'd3: sin_v = s;
            3'd1, 3'd2: sin_v = c;
            3'd4, 3'd7: sin_v = -s;
            default:    sin_v = -c;
        endcase
        dre = longint'(ar) - longint'(br);
        dim = longint'(ai) - longint'(bi);
        exp_x_re.push_back(SAMPLE_W'((longint'(ar) + longint'(br)) >>> 1));
        exp_x_im.push_back(SAMPLE_W'((longint'(ai) + longint'(bi)) >>> 1));
        exp_y_re.push_back(SAMPLE_W'((dre * cos_v + dim * sin_v) >>> Y_SHIFT));
        exp_y_im.push_back(SAMPLE_W'((dim * cos_v - dre * sin_v) >>> Y_SHIFT));
    endfunction

    task automatic send_item(
        input logic signed [SAMPLE_W-1:0] ar,
        input logic signed [SAMPLE_W-1:0] ai,
        input logic signed [SAMPLE_W-1:0] br,
        input logic signed [SAMPLE_W-1:0] bi,
        input logic [PHASE_W-1:0]         ph
    );
        @(posedge clk);
        in_valid <= 1'b1;
        a_re     <= ar;
        a_im     <= ai;
        b_re     <= br;
        b_im     <= bi;
        phase    <= ph;
        sent_count++;
        expect_result(ar, ai, br, bi, ph);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_credit(output bit ok);
        int stall;
        stall = 0;
        while (upstream_credits() == 0 && stall < DRAIN_LIMIT) begin
            idle_cycle();
            stall++;
        end
        ok = (upstream_credits() > 0);
        if (!ok) begin
            $display("upstream credit never came back after %0d cycles", stall);
            fail_count++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_x_re.size() != 0 && n < DRAIN_LIMIT) begin
            idle_cycle();
            n++;
        end
        if (exp_x_re.size() != 0) begin
            $display("%0d results never appeared within %0d cycles", exp_x_re.size(), n);
            fail_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks

    task automatic check_sample(input string name, input logic signed [SAMPLE_W-1:0] got,
                                input logic signed [SAMPLE_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic finish_test(input string name, input int fails_before);
        if (fail_count == fails_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d failures", name, fail_count - fails_before);
    endtask

    // result monitor and credit counters
    always @(negedge clk) begin
        if (!rst) begin
            if (in_credit)
                in_credit_count++;
            if (out_valid) begin
                out_count++;
                if (exp_x_re.size() == 0) begin
                    $display("result appeared while the model expected none");
                    fail_count++;
                end else begin
                    check_sample("x_re", x_re, exp_x_re.pop_front());
                    check_sample("x_im", x_im, exp_x_im.pop_front());
                    check_sample("y_re", y_re, exp_y_re.pop_front());
                    check_sample("y_im", y_im, exp_y_im.pop_front());
                end
            end
        end
    end

    // downstream hands each consumed slot back unless held
    always @(posedge clk) begin
        if (rst) begin
            out_credit <= 1'b0;
        end else if (!hold_credits && out_count > returned_count) begin
            out_credit <= 1'b1;
            returned_count++;
        end else begin
            out_credit <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_reset_state();
        int fails_before;
        fails_before = fail_count;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_credit", in_credit, 1'b0);
        end
        check_count("upstream credits", upstream_credits(), FIFO_DEPTH);
        finish_test("reset state", fails_before);
    endtask

    task automatic test_phase_zero();
        int fails_before;
        bit ok;
        fails_before = fail_count;
        for (int i = 0; i < PHASE0_ITEMS; i++) begin
            wait_credit(ok);
            if (!ok)
                break;
            send_item(random_bits(SAMPLE_W), random_bits(SAMPLE_W),
                      random_bits(SAMPLE_W), random_bits(SAMPLE_W), '0);
        end
        idle_cycle();
        wait_drain();
        finish_test("phase zero", fails_before);
    endtask

    task automatic test_octant_sweep();
        int fails_before;
        bit ok;
        fails_before = fail_count;
        for (int p = 0; p < SWEEP_ITEMS; p++) begin
            wait_credit(ok);
            if (!ok)
                break;
            send_item(16'sd12000, -16'sd7000, -16'sd9000, 16'sd5000, PHASE_W'(p));
        end
        idle_cycle();
        wait_drain();
        finish_test("octant sweep", fails_before);
    endtask

    task automatic test_back_pressure();
        int fails_before;
        int out_before;
        int sent_before;
        int idle;
        fails_before = fail_count;
        out_before   = out_count;
        sent_before  = sent_count;
        idle         = 0;
        hold_credits <= 1'b1;
        while ((sent_count - sent_before) < BP_ITEMS && idle < QUIET_CYCLES) begin
            if (upstream_credits() > 0) begin
                send_item(random_bits(SAMPLE_W), random_bits(SAMPLE_W),
                          random_bits(SAMPLE_W), random_bits(SAMPLE_W),
                          PHASE_W'(random_bits(PHASE_W)));
                idle = 0;
            end else begin
                idle_cycle();
                idle++;
            end
        end
        // nothing more may move while downstream is blocked
        repeat (QUIET_CYCLES) idle_cycle();
        check_count("results while blocked", out_count - out_before, OUT_CREDITS);
        check_count("items accepted", sent_count - sent_before, FIFO_DEPTH + OUT_CREDITS);
        check_count("upstream credits while blocked", upstream_credits(), 0);
        hold_credits <= 1'b0;
        wait_drain();
        check_count("results after release", out_count - out_before, sent_count - sent_before);
        finish_test("back-pressure", fails_before);
    endtask

    task automatic test_credit_conservation();
        int fails_before;
        bit ok;
        fails_before = fail_count;
        for (int i = 0; i < BURST_ITEMS; i++) begin
            if (random_bits(2) == 16'd0)
                idle_cycle();
            wait_credit(ok);
            if (!ok)
                break;
            send_item(random_bits(SAMPLE_W), random_bits(SAMPLE_W),
                      random_bits(SAMPLE_W), random_bits(SAMPLE_W),
                      PHASE_W'(random_bits(PHASE_W)));
        end
        idle_cycle();
        wait_drain();
        check_count("in_credit pulses", in_credit_count, out_count);
        check_count("results total", out_count, sent_count);
        check_count("upstream credits at end", upstream_credits(), FIFO_DEPTH);
        finish_test("credit conservation", fails_before);
    endtask

    initial begin
        lfsr     = 16'd26;
        in_valid = 1'b0;
        a_re     = '0;
        a_im     = '0;
        b_re     = '0;
        b_im     = '0;
        phase    = '0;
        $readmemh(TABLE_FILE, twiddle_table);
        wait (rst === 1'b0);
        test_reset_state();
        test_phase_zero();
        test_octant_sweep();
        test_back_pressure();
        test_credit_conservation();
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule
